// File: src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  // Command encoding on the shared memory bus
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_t;

  // Zero tag means the request was refused
  typedef logic [3:0] mem_tag_t;

  typedef logic [63:0] mem_addr_t;  // Byte address
  typedef logic [63:0] mem_data_t;  // One bus word, also one cache line

  localparam int MEM_LINE_BYTES = 8;

endpackage

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int FETCH_WIDTH = 2;  // Instructions per cache line

  // Direct-mapped instruction cache geometry
  localparam int ICACHE_LINES = 32;
  localparam int ICACHE_IDX_BITS = 5;
  localparam int ICACHE_TAG_BITS = 8;

  localparam int FB_DEPTH = 8;

  typedef logic [ICACHE_IDX_BITS-1:0] icache_idx_t;
  typedef logic [ICACHE_TAG_BITS-1:0] icache_tag_t;

  typedef logic [31:0] inst_t;
  typedef mem_bus_pkg::mem_addr_t pc_t;

  // Count needs one more bit than the pointer to tell full from empty
  typedef logic [$clog2(FB_DEPTH)-1:0] fb_ptr_t;
  typedef logic [$clog2(FB_DEPTH):0] fb_count_t;

endpackage

`default_nettype wire

// File: src/icache_mem.sv
`timescale 1ns/1ns
`default_nettype none

module icache_mem
  import mem_bus_pkg::*;
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        rst_n,
  input  logic        wr_en,
  input  icache_idx_t wr_idx,
  input  icache_tag_t wr_tag,
  input  mem_data_t   wr_data,
  input  icache_idx_t rd_idx,
  input  icache_tag_t rd_tag,
  output mem_data_t   rd_data,
  output logic        rd_valid
);

  mem_data_t   data_mem [ICACHE_LINES];
  icache_tag_t tag_mem  [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] valid_mem;

  assign rd_data  = data_mem[rd_idx];
  assign rd_valid = valid_mem[rd_idx] && (tag_mem[rd_idx] == rd_tag);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid_mem <= '0;
    end else if (wr_en) begin
      valid_mem[wr_idx] <= 1'b1;
    end
  end

  // Lines are never invalidated once filled
  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

endmodule

`default_nettype wire

// File: src/icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl
  import mem_bus_pkg::*;
  import fetch_pkg::*;
(
  input  logic         clock,
  input  logic         rst_n,
  input  pc_t          fetch_addr,
  input  mem_tag_t     mem_response,
  input  mem_data_t    mem_data,
  input  mem_tag_t     mem_tag,
  input  mem_data_t    cache_data,
  input  logic         cache_hit,
  output bus_command_t imem_command,
  output mem_addr_t    imem_addr,
  output mem_data_t    line,
  output logic         line_valid,
  output icache_idx_t  rd_idx,
  output icache_tag_t  rd_tag,
  output logic         wr_en,
  output icache_idx_t  wr_idx,
  output icache_tag_t  wr_tag
);

  logic        req_active;  // Refill request held on the bus
  mem_tag_t    pend_tag;    // Zero when no refill is outstanding
  icache_idx_t miss_idx;
  icache_tag_t miss_tag;
  logic        accepted;
  logic        fill;

  assign rd_idx = fetch_addr[$clog2(MEM_LINE_BYTES) +: ICACHE_IDX_BITS];
  assign rd_tag = fetch_addr[$clog2(MEM_LINE_BYTES) + ICACHE_IDX_BITS +: ICACHE_TAG_BITS];

  assign line       = cache_data;
  assign line_valid = cache_hit;

  assign accepted = req_active && (mem_response != '0);
  assign fill     = (pend_tag != '0) && (mem_tag == pend_tag);

  assign imem_command = req_active ? BUS_LOAD : BUS_NONE;
  assign imem_addr    = mem_addr_t'({miss_tag, miss_idx}) << $clog2(MEM_LINE_BYTES);

  assign wr_en  = fill;
  assign wr_idx = miss_idx;
  assign wr_tag = miss_tag;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req_active <= 1'b0;
      pend_tag   <= '0;
    end else begin
      if (!cache_hit && !req_active && (pend_tag == '0)) begin
        req_active <= 1'b1;
      end else if (accepted) begin
        req_active <= 1'b0;
      end
      if (accepted) begin
        pend_tag <= mem_response;
      end else if (fill) begin
        pend_tag <= '0;
      end
    end
  end

  // Missing line is captured once, so a redirect cannot change the refill
  always_ff @(posedge clock) begin
    if (!cache_hit && !req_active && (pend_tag == '0)) begin
      miss_idx <= rd_idx;
      miss_tag <= rd_tag;
    end
  end

  a_one_refill: assert property (@(posedge clock) disable iff (!rst_n)
    (pend_tag != '0) |-> (imem_command == BUS_NONE));

  // Memory must return a defined line for the tag it handed out
  a_fill_data_known: assert property (@(posedge clock) disable iff (!rst_n)
    fill |-> !$isunknown(mem_data));

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
  import mem_bus_pkg::*;
  import fetch_pkg::*;
(
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         fetch_en,
  input  logic                         redirect,
  input  pc_t                          redirect_pc,
  input  mem_data_t                    line,
  input  logic                         line_valid,
  output pc_t                          fetch_addr,
  output logic                         push,
  output inst_t [FETCH_WIDTH-1:0]      push_inst,
  output pc_t   [FETCH_WIDTH-1:0]      push_pc,
  output logic  [FETCH_WIDTH-1:0]      push_slot_valid
);

  pc_t pc;
  pc_t line_base;

  assign fetch_addr = pc;
  assign line_base  = pc & ~pc_t'(MEM_LINE_BYTES - 1);
  assign push       = line_valid && fetch_en && !redirect;

  always_comb begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      push_inst[i] = line[i*$bits(inst_t) +: $bits(inst_t)];
      push_pc[i]   = line_base + pc_t'(i * ($bits(inst_t) / 8));
      // Slots below the PC's word are skipped
      push_slot_valid[i] = (i >= int'(pc[2]));
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (push) begin
      pc <= line_base + pc_t'(MEM_LINE_BYTES);  // Next aligned line
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer
  import fetch_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    push,
  input  inst_t [FETCH_WIDTH-1:0] push_inst,
  input  pc_t   [FETCH_WIDTH-1:0] push_pc,
  input  logic  [FETCH_WIDTH-1:0] push_slot_valid,
  input  logic                    pop,
  output inst_t                   head_inst,
  output pc_t                     head_pc,
  output logic                    head_valid,
  output logic                    fetch_en
);

  inst_t inst_q [FB_DEPTH];
  pc_t   pc_q   [FB_DEPTH];

  fb_ptr_t   head;
  fb_ptr_t   tail;
  fb_count_t count;
  fb_count_t push_cnt;
  fb_ptr_t   slot_ptr [FETCH_WIDTH];
  logic      pop_ok;

  assign head_inst  = inst_q[head];
  assign head_pc    = pc_q[head];
  assign head_valid = (count != '0);
  assign fetch_en   = (count <= fb_count_t'(FB_DEPTH - FETCH_WIDTH));
  assign pop_ok     = pop && head_valid;

  // Valid slots pack behind the tail in slot order
  always_comb begin
    push_cnt = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      slot_ptr[i] = tail + fb_ptr_t'(push_cnt);
      if (push && push_slot_valid[i]) begin
        push_cnt = push_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + fb_ptr_t'(pop_ok);
      tail  <= tail + fb_ptr_t'(push_cnt);
      count <= count + push_cnt - fb_count_t'(pop_ok);
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (push && push_slot_valid[i]) begin
        inst_q[slot_ptr[i]] <= push_inst[i];
        pc_q[slot_ptr[i]]   <= push_pc[i];
      end
    end
  end

  // Fetch must honour fetch_en
  a_push_has_room: assert property (@(posedge clock) disable iff (!rst_n)
    push |-> (count <= fb_count_t'(FB_DEPTH - FETCH_WIDTH)));

endmodule

`default_nettype wire

// File: src/dmem_port.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_port
  import mem_bus_pkg::*;
(
  input  logic         clock,
  input  logic         rst_n,
  input  logic         req,
  input  bus_command_t command,
  input  mem_addr_t    addr,
  input  mem_data_t    wdata,
  input  mem_tag_t     mem_response,
  input  mem_data_t    mem_data,
  input  mem_tag_t     mem_tag,
  output bus_command_t dmem_command,
  output mem_addr_t    dmem_addr,
  output mem_data_t    dmem_data,
  output logic         busy,
  output mem_data_t    load_data,
  output logic         load_valid
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_DATA
  } dmem_state_t;

  dmem_state_t  state;
  bus_command_t cmd_q;
  mem_addr_t    addr_q;
  mem_data_t    wdata_q;
  mem_tag_t     pend_tag;
  logic         start;
  logic         accepted;
  logic         data_back;

  assign start     = (state == IDLE) && req && (command != BUS_NONE);
  assign accepted  = (state == REQUEST) && (mem_response != '0);
  assign data_back = (state == WAIT_DATA) && (mem_tag == pend_tag);

  assign busy         = (state != IDLE);
  assign dmem_command = (state == REQUEST) ? cmd_q : BUS_NONE;
  assign dmem_addr    = addr_q;
  assign dmem_data    = wdata_q;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      pend_tag   <= '0;
      load_valid <= 1'b0;
    end else begin
      load_valid <= data_back;
      if (accepted) begin
        pend_tag <= mem_response;
      end
      case (state)
        IDLE:      if (start) state <= REQUEST;
        REQUEST:   if (accepted) state <= (cmd_q == BUS_LOAD) ? WAIT_DATA : IDLE;  // Store done
        WAIT_DATA: if (data_back) state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      cmd_q   <= command;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (data_back) begin
      load_data <= mem_data;
    end
  end

  a_load_from_wait: assert property (@(posedge clock) disable iff (!rst_n)
    load_valid |-> ($past(state) == WAIT_DATA));

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
  import mem_bus_pkg::*;
(
  input  bus_command_t dmem_command,
  input  mem_addr_t    dmem_addr,
  input  mem_data_t    dmem_data,
  input  bus_command_t imem_command,
  input  mem_addr_t    imem_addr,
  input  mem_tag_t     mem2proc_response,
  output mem_tag_t     dmem_response,
  output mem_tag_t     imem_response,
  output bus_command_t proc2mem_command,
  output mem_addr_t    proc2mem_addr,
  output mem_data_t    proc2mem_data
);

  logic dmem_sel;

  // Data side always wins
  assign dmem_sel = (dmem_command != BUS_NONE);

  assign proc2mem_command = dmem_sel ? dmem_command : imem_command;
  assign proc2mem_addr    = dmem_sel ? dmem_addr : imem_addr;
  assign proc2mem_data    = dmem_sel ? dmem_data : '0;  // Cache only loads

  // Loser sees a refusal
  assign dmem_response = dmem_sel ? mem2proc_response : '0;
  assign imem_response = dmem_sel ? '0 : mem2proc_response;

endmodule

`default_nettype wire

// File: src/fetch_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_front_end
  import mem_bus_pkg::*;
  import fetch_pkg::*;
(
  input  logic         clock,
  input  logic         rst_n,
  input  mem_tag_t     mem2proc_response,
  input  mem_data_t    mem2proc_data,
  input  mem_tag_t     mem2proc_tag,
  output bus_command_t proc2mem_command,
  output mem_addr_t    proc2mem_addr,
  output mem_data_t    proc2mem_data,
  input  logic         redirect,
  input  pc_t          redirect_pc,
  input  logic         take_inst,
  output inst_t        inst,
  output pc_t          inst_pc,
  output logic         inst_valid,
  input  logic         dmem_req,
  input  bus_command_t dmem_command,
  input  mem_addr_t    dmem_addr,
  input  mem_data_t    dmem_wdata,
  output logic         dmem_busy,
  output mem_data_t    dmem_load_data,
  output logic         dmem_load_valid
);

  mem_data_t    cache_data;
  logic         cache_hit;
  icache_idx_t  rd_idx;
  icache_tag_t  rd_tag;
  logic         wr_en;
  icache_idx_t  wr_idx;
  icache_tag_t  wr_tag;
  pc_t          fetch_addr;
  mem_data_t    line;
  logic         line_valid;
  bus_command_t imem_command;
  mem_addr_t    imem_addr;
  mem_tag_t     imem_response;
  bus_command_t dmem_bus_command;
  mem_addr_t    dmem_bus_addr;
  mem_data_t    dmem_bus_data;
  mem_tag_t     dmem_response;
  logic         fetch_en;
  logic         push;
  inst_t [FETCH_WIDTH-1:0] push_inst;
  pc_t   [FETCH_WIDTH-1:0] push_pc;
  logic  [FETCH_WIDTH-1:0] push_slot_valid;

  icache_mem icache_mem_0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_tag   (wr_tag),
    .wr_data  (mem2proc_data),  // Refill line straight from the bus
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .rd_data  (cache_data),
    .rd_valid (cache_hit)
  );

  icache_ctrl icache_ctrl_0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .fetch_addr   (fetch_addr),
    .mem_response (imem_response),
    .mem_data     (mem2proc_data),
    .mem_tag      (mem2proc_tag),
    .cache_data   (cache_data),
    .cache_hit    (cache_hit),
    .imem_command (imem_command),
    .imem_addr    (imem_addr),
    .line         (line),
    .line_valid   (line_valid),
    .rd_idx       (rd_idx),
    .rd_tag       (rd_tag),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_tag       (wr_tag)
  );

  fetch_stage fetch_stage_0 (
    .clock           (clock),
    .rst_n           (rst_n),
    .fetch_en        (fetch_en),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .line            (line),
    .line_valid      (line_valid),
    .fetch_addr      (fetch_addr),
    .push            (push),
    .push_inst       (push_inst),
    .push_pc         (push_pc),
    .push_slot_valid (push_slot_valid)
  );

  fetch_buffer fetch_buffer_0 (
    .clock           (clock),
    .rst_n           (rst_n),
    .flush           (redirect),
    .push            (push),
    .push_inst       (push_inst),
    .push_pc         (push_pc),
    .push_slot_valid (push_slot_valid),
    .pop             (take_inst),
    .head_inst       (inst),
    .head_pc         (inst_pc),
    .head_valid      (inst_valid),
    .fetch_en        (fetch_en)
  );

  dmem_port dmem_port_0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .req          (dmem_req),
    .command      (dmem_command),
    .addr         (dmem_addr),
    .wdata        (dmem_wdata),
    .mem_response (dmem_response),
    .mem_data     (mem2proc_data),
    .mem_tag      (mem2proc_tag),
    .dmem_command (dmem_bus_command),
    .dmem_addr    (dmem_bus_addr),
    .dmem_data    (dmem_bus_data),
    .busy         (dmem_busy),
    .load_data    (dmem_load_data),
    .load_valid   (dmem_load_valid)
  );

  mem_arbiter mem_arbiter_0 (
    .dmem_command      (dmem_bus_command),
    .dmem_addr         (dmem_bus_addr),
    .dmem_data         (dmem_bus_data),
    .imem_command      (imem_command),
    .imem_addr         (imem_addr),
    .mem2proc_response (mem2proc_response),
    .dmem_response     (dmem_response),
    .imem_response     (imem_response),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data)
  );

endmodule

`default_nettype wire

// File: verif/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model
  import mem_bus_pkg::*;
(
  input  logic         clock,
  input  logic         rst_n,
  input  bus_command_t proc2mem_command,
  input  mem_addr_t    proc2mem_addr,
  input  mem_data_t    proc2mem_data,
  output mem_tag_t     mem2proc_response,
  output mem_data_t    mem2proc_data,
  output mem_tag_t     mem2proc_tag
);

  localparam int LOAD_LATENCY = 4;
  localparam int MEM_WORDS = 8192;  // Bits 15:3 of the address

  mem_data_t mem [MEM_WORDS];
  mem_tag_t  pipe_tag [LOAD_LATENCY];
  mem_data_t pipe_data [LOAD_LATENCY];
  mem_tag_t  next_tag;
  logic      refuse = 1'b0;
  integer    seed = 32'hfcb4_23aa;

  // Initial word at byte address a
  function automatic logic [31:0] word_at(input logic [15:0] a);
    return {a, a ^ 16'hc3a5};
  endfunction

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {word_at(16'(i * 8 + 4)), word_at(16'(i * 8))};
    end
  end

  // Roughly one cycle in four refuses
  always @(negedge clock) begin
    refuse <= (($random(seed) & 3) == 0);
  end

  assign mem2proc_response = ((proc2mem_command != BUS_NONE) && !refuse) ? next_tag : 4'h0;

  assign mem2proc_tag  = pipe_tag[LOAD_LATENCY-1];
  assign mem2proc_data = pipe_data[LOAD_LATENCY-1];

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      next_tag <= 4'h1;
      for (int i = 0; i < LOAD_LATENCY; i++) begin
        pipe_tag[i]  <= '0;
        pipe_data[i] <= '0;
      end
    end else begin
      for (int i = LOAD_LATENCY - 1; i > 0; i--) begin
        pipe_tag[i]  <= pipe_tag[i-1];
        pipe_data[i] <= pipe_data[i-1];
      end
      pipe_tag[0] <= '0;
      if (mem2proc_response != '0) begin
        next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;  // Zero is never handed out
        if (proc2mem_command == BUS_STORE) begin
          mem[proc2mem_addr[15:3]] <= proc2mem_data;
        end else begin
          pipe_tag[0]  <= next_tag;
          pipe_data[0] <= mem[proc2mem_addr[15:3]];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_fetch_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_front_end
  import mem_bus_pkg::*;
  import fetch_pkg::*;
;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 3;
  localparam int STALL_LIMIT = 200;
  localparam int CYCLES_PER_INST = 24;
  localparam int TOTAL_INSTS = 24 + 16 + 40 + 24 + 12;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_INSTS * CYCLES_PER_INST + 600;

  logic         clock;
  logic         rst_n;
  mem_tag_t     mem2proc_response;
  mem_data_t    mem2proc_data;
  mem_tag_t     mem2proc_tag;
  bus_command_t proc2mem_command;
  mem_addr_t    proc2mem_addr;
  mem_data_t    proc2mem_data;
  logic         redirect;
  pc_t          redirect_pc;
  logic         take_inst;
  inst_t        inst;
  pc_t          inst_pc;
  logic         inst_valid;
  logic         dmem_req;
  bus_command_t dmem_command;
  mem_addr_t    dmem_addr;
  mem_data_t    dmem_wdata;
  logic         dmem_busy;
  mem_data_t    dmem_load_data;
  logic         dmem_load_valid;

  integer seed = 32'hfcb4_23aa;
  int     error_count = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  logic   stream_done;

  fetch_front_end fetch_front_end_inst (
    .clock             (clock),
    .rst_n             (rst_n),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .take_inst         (take_inst),
    .inst              (inst),
    .inst_pc           (inst_pc),
    .inst_valid        (inst_valid),
    .dmem_req          (dmem_req),
    .dmem_command      (dmem_command),
    .dmem_addr         (dmem_addr),
    .dmem_wdata        (dmem_wdata),
    .dmem_busy         (dmem_busy),
    .dmem_load_data    (dmem_load_data),
    .dmem_load_valid   (dmem_load_valid)
  );

  tb_mem_model mem_model_inst (
    .clock             (clock),
    .rst_n             (rst_n),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests never finished", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  // Memory fill rule for the word at a byte address
  function automatic inst_t expected_inst(input pc_t a);
    return {a[15:0], a[15:0] ^ 16'hc3a5};
  endfunction

  task automatic check_inst(input inst_t actual, input inst_t expected, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_pc(input pc_t actual, input pc_t expected, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_data(input mem_data_t actual, input mem_data_t expected,
                            input string what);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_command(input bus_command_t actual, input bus_command_t expected,
                               input string what);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s got %s expected %s", $time, what, actual.name(),
               expected.name());
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic redirect_to(input pc_t target);
    @(negedge clock);
    take_inst   = 1'b0;
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clock);
    redirect = 1'b0;
  endtask

  // Pops count instructions and expects consecutive PCs from start_pc
  task automatic consume_stream(input pc_t start_pc, input int count, input logic pauses);
    pc_t exp_pc;
    int  got;
    int  idle;
    int  pause_left;
    int  errs;
    exp_pc     = start_pc;
    got        = 0;
    idle       = 0;
    pause_left = 0;
    errs       = error_count;
    while ((got < count) && (idle < STALL_LIMIT) && (error_count == errs)) begin
      @(negedge clock);
      take_inst = 1'b0;
      if (pause_left > 0) begin
        pause_left--;
      end else if (pauses && (($random(seed) & 3) == 0)) begin
        pause_left = $random(seed) & 7;
      end else if (inst_valid) begin
        check_pc(inst_pc, exp_pc, "inst_pc");
        check_inst(inst, expected_inst(exp_pc), "inst");
        take_inst = 1'b1;
        exp_pc    = exp_pc + 4;
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    @(negedge clock);
    take_inst = 1'b0;
    if ((got < count) && (error_count == errs)) begin
      error_count++;
      $display("No instruction arrived for %0d cycles after %0d of %0d were taken",
               STALL_LIMIT, got, count);
    end
  endtask

  task automatic wait_bus_idle();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while ((quiet < 8) && (waited < STALL_LIMIT)) begin
      @(negedge clock);
      waited++;
      quiet = (proc2mem_command == BUS_NONE) ? quiet + 1 : 0;
    end
    if (quiet < 8) begin
      error_count++;
      $display("Memory bus never went quiet within %0d cycles", STALL_LIMIT);
    end
  endtask

  task automatic store_then_load(input mem_addr_t addr, input mem_data_t value);
    int waited;
    @(negedge clock);
    dmem_req     = 1'b1;
    dmem_command = BUS_STORE;
    dmem_addr    = addr;
    dmem_wdata   = value;
    @(negedge clock);
    dmem_req     = 1'b0;
    dmem_command = BUS_NONE;
    waited       = 0;
    while (dmem_busy && (waited < STALL_LIMIT)) begin
      @(negedge clock);
      waited++;
    end
    if (dmem_busy) begin
      error_count++;
      $display("Store was not accepted within %0d cycles", STALL_LIMIT);
    end else begin
      dmem_req     = 1'b1;
      dmem_command = BUS_LOAD;
      dmem_wdata   = '0;
      @(negedge clock);
      dmem_req     = 1'b0;
      dmem_command = BUS_NONE;
      waited       = 0;
      while (!dmem_load_valid && (waited < STALL_LIMIT)) begin
        @(negedge clock);
        waited++;
      end
      if (dmem_load_valid) begin
        check_data(dmem_load_data, value, "dmem_load_data");
      end else begin
        error_count++;
        $display("Load data did not return within %0d cycles", STALL_LIMIT);
      end
    end
  endtask

  task automatic after_reset_idle();
    int errs;
    errs = error_count;
    check_command(proc2mem_command, BUS_NONE, "proc2mem_command after reset");
    check_flag(inst_valid, 1'b0, "inst_valid after reset");
    check_flag(dmem_busy, 1'b0, "dmem_busy after reset");
    finish_test("reset state", errs);
  endtask

  task automatic aligned_stream();
    int errs;
    errs = error_count;
    redirect_to(64'h0400);
    consume_stream(64'h0400, 24, 1'b0);
    finish_test("aligned stream", errs);
  endtask

  task automatic upper_half_redirect();
    int errs;
    errs = error_count;
    redirect_to(64'h0a04);  // Buffer still holds entries from the last stream
    consume_stream(64'h0a04, 16, 1'b0);
    finish_test("upper half redirect", errs);
  endtask

  task automatic stalls_and_refusals();
    int errs;
    errs = error_count;
    redirect_to(64'h1000);
    consume_stream(64'h1000, 40, 1'b1);
    finish_test("stalls and refusals", errs);
  endtask

  task automatic store_load_while_fetching();
    int errs;
    errs = error_count;
    redirect_to(64'h2000);
    fork
      consume_stream(64'h2000, 24, 1'b0);
      store_then_load(64'h6f28, 64'h5eed_0123_4567_89ab);
    join
    finish_test("store and load during fetch", errs);
  endtask

  // Lines 0x2000 and up were filled by the previous test
  task automatic cached_region_replay();
    int errs;
    errs = error_count;
    wait_bus_idle();
    stream_done = 1'b0;
    redirect_to(64'h2000);
    fork
      begin
        consume_stream(64'h2000, 12, 1'b0);
        stream_done = 1'b1;
      end
      while (!stream_done) begin
        @(negedge clock);
        check_command(proc2mem_command, BUS_NONE, "proc2mem_command on cached replay");
      end
    join
    finish_test("cached region replay", errs);
  endtask

  initial begin
    rst_n        = 1'b0;
    redirect     = 1'b0;
    redirect_pc  = '0;
    take_inst    = 1'b0;
    dmem_req     = 1'b0;
    dmem_command = BUS_NONE;
    dmem_addr    = '0;
    dmem_wdata   = '0;
    stream_done  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock);
    rst_n = 1'b1;

    after_reset_idle();
    aligned_stream();
    upper_half_redirect();
    stalls_and_refusals();
    store_load_while_fetching();
    cached_region_replay();

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/mem_bus_pkg.sv
src/fetch_pkg.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/fetch_stage.sv
src/fetch_buffer.sv
src/dmem_port.sv
src/mem_arbiter.sv
src/fetch_front_end.sv
verif/tb_mem_model.sv
verif/tb_fetch_front_end.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - src/mem_bus_pkg.sv
  - src/fetch_pkg.sv
  - src/icache_mem.sv
  - src/icache_ctrl.sv
  - src/fetch_stage.sv
  - src/fetch_buffer.sv
  - src/dmem_port.sv
  - src/mem_arbiter.sv
  - src/fetch_front_end.sv
  - target: test
    files:
      - verif/tb_mem_model.sv
      - verif/tb_fetch_front_end.sv
